/* design/vi_pkg.sv */
// Data widths, operation codes and the issue, execute and write-back packet types
package vi_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int TAG_W      = 8;
	localparam int NUM_REGS   = 2 ** REG_ADDR_W;
	localparam int SHAMT_W    = $clog2(XLEN);

	// Integer operations, MUL is the only one routed to the multiply pipe
	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		AND = 4'd2,
		OR  = 4'd3,
		XOR = 4'd4,
		SLL = 4'd5,
		SRL = 4'd6,
		SLT = 4'd7,
		MUL = 4'd8
	} op_e;

	// Operation as presented on the issue port
	typedef struct packed {
		op_e                   op;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [TAG_W-1:0]      tag;
	} issue_t;

	// Contents of the execute latch, operands already resolved
	typedef struct packed {
		logic                  valid;
		op_e                   op;
		logic [REG_ADDR_W-1:0] rd;
		logic [TAG_W-1:0]      tag;
		logic [XLEN-1:0]       op_a;
		logic [XLEN-1:0]       op_b;
	} exe_t;

	// Result in flight or retiring
	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] rd;
		logic [TAG_W-1:0]      tag;
		logic [XLEN-1:0]       data;
	} wb_t;

endpackage

/* design/int_registers.sv */
// Integer register file with two read ports, one write port and register zero tied to zero
`timescale 1ns/1ns

module int_registers (
	input  logic                          clk_i,
	input  logic                          arst_n_i,
	input  logic [vi_pkg::REG_ADDR_W-1:0] read_addr_a_i,
	input  logic [vi_pkg::REG_ADDR_W-1:0] read_addr_b_i,
	input  vi_pkg::wb_t                   write_i,
	output logic [vi_pkg::XLEN-1:0]       read_data_a_o,
	output logic [vi_pkg::XLEN-1:0]       read_data_b_o
);
	import vi_pkg::*;

	logic [XLEN-1:0] regs [NUM_REGS];

	// Register zero is never written, so its reset value stays
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_i.valid && (write_i.rd != '0)) begin
			regs[write_i.rd] <= write_i.data;
		end
	end

	assign read_data_a_o = regs[read_addr_a_i];
	assign read_data_b_o = regs[read_addr_b_i];

	// Holds across every retirement, including those that target r0
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(read_addr_a_i == '0) |-> (read_data_a_o == '0))
	else
		$error("register zero read back a nonzero value");

endmodule

/* design/int_alu.sv */
// Combinational integer ALU for add, subtract, logic, shifts and set-less-than
`timescale 1ns/1ns

module int_alu (
	input  vi_pkg::exe_t            exe_i,
	output logic [vi_pkg::XLEN-1:0] data_o
);
	import vi_pkg::*;

	logic [SHAMT_W-1:0] shamt;

	assign shamt = exe_i.op_b[SHAMT_W-1:0];

	always_comb begin
		unique case (exe_i.op)
			ADD: begin
				data_o = exe_i.op_a + exe_i.op_b;
			end
			SUB: begin
				data_o = exe_i.op_a - exe_i.op_b;
			end
			AND: begin
				data_o = exe_i.op_a & exe_i.op_b;
			end
			OR: begin
				data_o = exe_i.op_a | exe_i.op_b;
			end
			XOR: begin
				data_o = exe_i.op_a ^ exe_i.op_b;
			end
			SLL: begin
				data_o = exe_i.op_a << shamt;
			end
			SRL: begin
				data_o = exe_i.op_a >> shamt;
			end
			SLT: begin
				data_o = {{(XLEN-1){1'b0}}, $signed(exe_i.op_a) < $signed(exe_i.op_b)};
			end
			// Handled by the multiply pipe
			default: begin
				data_o = '0;
			end
		endcase
	end

endmodule

/* design/mult_pipe.sv */
// Multiply pipeline carrying product, destination and tag through MULT_STAGES stages
`timescale 1ns/1ns

module mult_pipe #(
	parameter int MULT_STAGES = 5
) (
	input  logic                                          clk_i,
	input  logic                                          arst_n_i,
	input  vi_pkg::exe_t                                  exe_i,
	output logic [MULT_STAGES-1:0]                        busy_o,
	output logic [MULT_STAGES-1:0][vi_pkg::REG_ADDR_W-1:0] rd_o,
	output vi_pkg::wb_t                                   result_o
);
	import vi_pkg::*;

	logic                                   take;
	logic [MULT_STAGES-1:0]                 valid_q;
	logic [MULT_STAGES-1:0][REG_ADDR_W-1:0] rd_q;
	logic [MULT_STAGES-1:0][TAG_W-1:0]      tag_q;
	logic [MULT_STAGES-1:0][XLEN-1:0]       prod_q;

	assign take = exe_i.valid && (exe_i.op == MUL);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[MULT_STAGES-2:0], take};
		end
	end

	// Low half of the product is formed in stage one, later stages only delay it
	always_ff @(posedge clk_i) begin
		prod_q[0] <= exe_i.op_a * exe_i.op_b;
		rd_q[0]   <= exe_i.rd;
		tag_q[0]  <= exe_i.tag;
		for (int i = 1; i < MULT_STAGES; i++) begin
			prod_q[i] <= prod_q[i-1];
			rd_q[i]   <= rd_q[i-1];
			tag_q[i]  <= tag_q[i-1];
		end
	end

	assign busy_o = valid_q;
	assign rd_o   = rd_q;

	assign result_o = '{
		valid: valid_q[MULT_STAGES-1],
		rd:    rd_q[MULT_STAGES-1],
		tag:   tag_q[MULT_STAGES-1],
		data:  prod_q[MULT_STAGES-1]
	};

endmodule

/* design/issue_stage.sv */
// Issue stage with operand read, forwarding, hazard stall and the execute latch
`timescale 1ns/1ns

module issue_stage #(
	parameter int MULT_STAGES = 5
) (
	input  logic                                          clk_i,
	input  logic                                          arst_n_i,
	input  logic                                          issue_valid_i,
	input  vi_pkg::issue_t                                issue_i,
	output logic [vi_pkg::REG_ADDR_W-1:0]                 read_addr_a_o,
	output logic [vi_pkg::REG_ADDR_W-1:0]                 read_addr_b_o,
	input  logic [vi_pkg::XLEN-1:0]                       read_data_a_i,
	input  logic [vi_pkg::XLEN-1:0]                       read_data_b_i,
	input  logic [vi_pkg::XLEN-1:0]                       alu_data_i,
	input  vi_pkg::wb_t                                   wb_i,
	input  logic [MULT_STAGES-1:0]                        mult_busy_i,
	input  logic [MULT_STAGES-1:0][vi_pkg::REG_ADDR_W-1:0] mult_rd_i,
	output logic                                          issue_stall_o,
	output vi_pkg::exe_t                                  exe_o
);
	import vi_pkg::*;

	logic                   exe_is_mul;
	logic                   exe_mul_rs1;
	logic                   exe_mul_rs2;
	logic                   exe_mul_rd;
	logic [MULT_STAGES-1:0] rs1_hit;
	logic [MULT_STAGES-1:0] rs2_hit;
	logic [MULT_STAGES-1:0] rd_hit;
	logic                   raw_stall;
	logic                   waw_stall;
	logic                   port_stall;
	logic [XLEN-1:0]        op_a;
	logic [XLEN-1:0]        op_b;
	exe_t                   exe_d;

	// ALU result in execute first, then write-back, then the register file
	function automatic logic [XLEN-1:0] forward(
		input logic [REG_ADDR_W-1:0] rs,
		input logic [XLEN-1:0]       rf_data,
		input exe_t                  exe,
		input logic [XLEN-1:0]       alu_data,
		input wb_t                   wb
	);
		if (rs == '0)
			return '0;
		if (exe.valid && (exe.op != MUL) && (exe.rd == rs))
			return alu_data;
		if (wb.valid && (wb.rd == rs))
			return wb.data;
		return rf_data;
	endfunction

	assign read_addr_a_o = issue_i.rs1;
	assign read_addr_b_o = issue_i.rs2;

	assign exe_is_mul  = exe_o.valid && (exe_o.op == MUL);
	assign exe_mul_rs1 = exe_is_mul && (exe_o.rd == issue_i.rs1);
	assign exe_mul_rs2 = exe_is_mul && (exe_o.rd == issue_i.rs2);
	assign exe_mul_rd  = exe_is_mul && (exe_o.rd == issue_i.rd);

	always_comb begin
		for (int i = 0; i < MULT_STAGES; i++) begin
			rs1_hit[i] = mult_busy_i[i] && (mult_rd_i[i] == issue_i.rs1);
			rs2_hit[i] = mult_busy_i[i] && (mult_rd_i[i] == issue_i.rs2);
			rd_hit[i]  = mult_busy_i[i] && (mult_rd_i[i] == issue_i.rd);
		end
	end

	// Products are only visible once they reach the write-back latch
	assign raw_stall = ((issue_i.rs1 != '0) && ((|rs1_hit) || exe_mul_rs1)) ||
	                   ((issue_i.rs2 != '0) && ((|rs2_hit) || exe_mul_rs2));
	assign waw_stall = (|rd_hit) || exe_mul_rd;
	// Stage that reaches write-back one edge after this op leaves execute
	assign port_stall = (issue_i.op != MUL) && mult_busy_i[MULT_STAGES-2];

	assign issue_stall_o = issue_valid_i && (raw_stall || waw_stall || port_stall);

	assign op_a = forward(issue_i.rs1, read_data_a_i, exe_o, alu_data_i, wb_i);
	assign op_b = forward(issue_i.rs2, read_data_b_i, exe_o, alu_data_i, wb_i);

	always_comb begin
		exe_d = '0;
		if (issue_valid_i && !issue_stall_o) begin
			exe_d = '{valid: 1'b1, op: issue_i.op, rd: issue_i.rd, tag: issue_i.tag,
			          op_a: op_a, op_b: op_b};
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			exe_o <= '0;
		end else begin
			exe_o <= exe_d;
		end
	end

	// A stalled operation stays on the issue port until it is accepted
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		issue_stall_o |=> (issue_valid_i && $stable(issue_i)))
	else
		$error("issue port changed while its operation was stalled");

endmodule

/* design/exe_write_latch.sv */
// Write-back latch merging the ALU and multiply results into one register write
`timescale 1ns/1ns

module exe_write_latch (
	input  logic                    clk_i,
	input  logic                    arst_n_i,
	input  vi_pkg::exe_t            exe_i,
	input  logic [vi_pkg::XLEN-1:0] alu_data_i,
	input  vi_pkg::wb_t             mult_i,
	output vi_pkg::wb_t             wb_o
);
	import vi_pkg::*;

	logic alu_sel;
	wb_t  wb_d;

	assign alu_sel = exe_i.valid && (exe_i.op != MUL);

	always_comb begin
		if (alu_sel) begin
			wb_d = '{valid: 1'b1, rd: exe_i.rd, tag: exe_i.tag, data: alu_data_i};
		end else if (mult_i.valid) begin
			wb_d = mult_i;
		end else begin
			wb_d = '0;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_o <= '0;
		end else begin
			wb_o <= wb_d;
		end
	end

	// Issue must have held back the ALU op that would collide here
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!(alu_sel && mult_i.valid))
	else
		$error("ALU and multiply results reached write-back together");

endmodule

/* design/vi_exec_core.sv */
// Top level of the integer back end with register file, issue, ALU, multiply and write-back
`timescale 1ns/1ns

module vi_exec_core #(
	parameter int MULT_STAGES = 5
) (
	input  logic           clk_i,
	input  logic           arst_n_i,
	input  logic           issue_valid_i,
	input  vi_pkg::issue_t issue_i,
	output logic           issue_stall_o,
	output vi_pkg::wb_t    retire_o
);
	import vi_pkg::*;

	// Register file read side
	logic [REG_ADDR_W-1:0] rf_addr_a;
	logic [REG_ADDR_W-1:0] rf_addr_b;
	logic [XLEN-1:0]       rf_data_a;
	logic [XLEN-1:0]       rf_data_b;

	// Execute stage
	exe_t                  exe;
	logic [XLEN-1:0]       alu_data;

	// Multiply pipe
	logic [MULT_STAGES-1:0]                 mult_busy;
	logic [MULT_STAGES-1:0][REG_ADDR_W-1:0] mult_rd;
	wb_t                                    mult_result;

	// Write-back latch output, also the retirement port
	wb_t                   wb;

	assign retire_o = wb;

	int_registers int_registers (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.read_addr_a_i (rf_addr_a),
		.read_addr_b_i (rf_addr_b),
		.write_i       (wb),
		.read_data_a_o (rf_data_a),
		.read_data_b_o (rf_data_b)
	);

	issue_stage #(
		.MULT_STAGES (MULT_STAGES)
	) issue_stage (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.issue_valid_i (issue_valid_i),
		.issue_i       (issue_i),
		.read_addr_a_o (rf_addr_a),
		.read_addr_b_o (rf_addr_b),
		.read_data_a_i (rf_data_a),
		.read_data_b_i (rf_data_b),
		.alu_data_i    (alu_data),
		.wb_i          (wb),
		.mult_busy_i   (mult_busy),
		.mult_rd_i     (mult_rd),
		.issue_stall_o (issue_stall_o),
		.exe_o         (exe)
	);

	int_alu int_alu (
		.exe_i  (exe),
		.data_o (alu_data)
	);

	mult_pipe #(
		.MULT_STAGES (MULT_STAGES)
	) mult_pipe (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.exe_i    (exe),
		.busy_o   (mult_busy),
		.rd_o     (mult_rd),
		.result_o (mult_result)
	);

	exe_write_latch exe_write_latch (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.exe_i      (exe),
		.alu_data_i (alu_data),
		.mult_i     (mult_result),
		.wb_o       (wb)
	);

endmodule

/* dv/tb_table.svh */
// Stimulus table with fixed initial register values and the operation sequence
task automatic load_table();
	foreach (fixed_seed[r]) begin
		fixed_seed[r] = '0;
	end
	// Sign and shift corner values, a zero entry gets a random value
	fixed_seed[1] = 32'h8000_0000;
	fixed_seed[2] = 32'h7fff_ffff;
	fixed_seed[3] = 32'hffff_ffff;
	fixed_seed[4] = 32'h0000_0007;
	// Bit five set, only the low five bits shift
	fixed_seed[5] = 32'h0000_0023;

	// op, rd, rs1, rs2, tag, back-to-back without stall
	steps.push_back(row(ADD, 10, 1, 2, 8'h40, 1'b0));
	steps.push_back(row(SUB, 11, 1, 2, 8'h41, 1'b0));
	steps.push_back(row(AND, 12, 3, 6, 8'h42, 1'b0));
	steps.push_back(row(XOR, 13, 9, 3, 8'h43, 1'b0));
	steps.push_back(row(SLL, 14, 3, 5, 8'h44, 1'b0));
	steps.push_back(row(SRL, 15, 1, 4, 8'h45, 1'b0));
	steps.push_back(row(SLT, 16, 1, 2, 8'h46, 1'b0));
	steps.push_back(row(SLT, 17, 2, 3, 8'h47, 1'b0));
	// Dependent chain fed by forwarding from execute and write-back
	steps.push_back(row(ADD, 20, 6, 7, 8'h48, 1'b0));
	steps.push_back(row(SUB, 21, 20, 8, 8'h49, 1'b1));
	steps.push_back(row(XOR, 22, 21, 20, 8'h4a, 1'b1));
	steps.push_back(row(OR, 23, 22, 21, 8'h4b, 1'b1));
	steps.push_back(row(AND, 24, 23, 20, 8'h4c, 1'b1));
	// Independent multiplies in flight together
	steps.push_back(row(MUL, 25, 1, 3, 8'h4d, 1'b0));
	steps.push_back(row(MUL, 26, 2, 9, 8'h4e, 1'b1));
	steps.push_back(row(MUL, 27, 8, 4, 8'h4f, 1'b1));
	steps.push_back(row(MUL, 28, 7, 6, 8'h50, 1'b1));
	// Reads and writes of registers owned by a multiply
	steps.push_back(row(ADD, 29, 25, 26, 8'h51, 1'b0));
	steps.push_back(row(MUL, 10, 11, 12, 8'h52, 1'b0));
	steps.push_back(row(ADD, 10, 10, 13, 8'h53, 1'b0));
	steps.push_back(row(MUL, 11, 3, 3, 8'h54, 1'b0));
	steps.push_back(row(XOR, 11, 4, 5, 8'h55, 1'b0));
	// Register zero as destination and as source
	steps.push_back(row(ADD, 0, 1, 2, 8'h56, 1'b0));
	steps.push_back(row(OR, 13, 0, 3, 8'h57, 1'b1));
	steps.push_back(row(MUL, 0, 3, 4, 8'h58, 1'b0));
	steps.push_back(row(SUB, 15, 0, 5, 8'h59, 1'b0));
endtask

/* dv/tb_vi_exec_core.sv */
// Testbench for the integer back end with clock, reset, table loop, reference model and checks
`timescale 1ns/1ns

module tb_vi_exec_core;
	import vi_pkg::*;

	localparam int MULT_STAGES = 5;
	localparam int TAGS        = 2 ** TAG_W;
	localparam int TIMEOUT     = 200;

	typedef struct packed {
		issue_t op;
		logic   chain;
	} step_t;

	logic                  clk;
	logic                  arst_n;
	logic                  issue_valid;
	issue_t                issue;
	logic                  issue_stall;
	wb_t                   retire;
	logic [XLEN-1:0]       seed_value;
	logic [XLEN-1:0]       ref_regs [NUM_REGS];
	logic [XLEN-1:0]       fixed_seed [NUM_REGS];
	int                    last_seq [NUM_REGS];
	logic [XLEN-1:0]       exp_data [TAGS];
	logic [REG_ADDR_W-1:0] exp_rd [TAGS];
	// Issue order of each tag or -1 while unused
	int                    exp_seq [TAGS];
	logic                  retired [TAGS];
	step_t                 steps [$];
	int                    issued;
	int                    retired_count;
	int                    checks;
	int                    errors;

	vi_exec_core #(
		.MULT_STAGES (MULT_STAGES)
	) DUT (
		.clk_i         (clk),
		.arst_n_i      (arst_n),
		.issue_valid_i (issue_valid),
		.issue_i       (issue),
		.issue_stall_o (issue_stall),
		.retire_o      (retire)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic step_t row(input op_e op, input int rd, input int rs1, input int rs2,
		input int tag, input logic chain);
		step_t s;
		s.op.op  = op;
		s.op.rd  = rd[REG_ADDR_W-1:0];
		s.op.rs1 = rs1[REG_ADDR_W-1:0];
		s.op.rs2 = rs2[REG_ADDR_W-1:0];
		s.op.tag = tag[TAG_W-1:0];
		s.chain  = chain;
		return s;
	endfunction

	`include "tb_table.svh"

	function automatic logic [XLEN-1:0] reference_result(input op_e op,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [2*XLEN-1:0] product;
		product = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
		case (op)
			ADD: return a + b;
			SUB: return a - b;
			AND: return a & b;
			OR:  return a | b;
			XOR: return a ^ b;
			SLL: return a << b[4:0];
			SRL: return a >> b[4:0];
			// Differing signs decide by the sign of a
			SLT: return (a[XLEN-1] != b[XLEN-1]) ? {{(XLEN-1){1'b0}}, a[XLEN-1]}
			                                     : {{(XLEN-1){1'b0}}, a < b};
			MUL: return product[XLEN-1:0];
			default: return '0;
		endcase
	endfunction

	task automatic finish_run();
		$display("checks %0d, errors %0d, retired %0d of %0d",
			checks, errors, retired_count, issued);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	endtask

	task automatic expect_result(input issue_t op, input logic [XLEN-1:0] data);
		exp_seq[op.tag]  = issued;
		exp_rd[op.tag]   = op.rd;
		exp_data[op.tag] = data;
		issued++;
	endtask

	// Called just after a rising edge and returns after the edge that accepts the operation
	task automatic issue_op(input issue_t op, input logic no_stall,
		input logic [XLEN-1:0] rf_value, output logic accepted);
		int waited;
		waited = 0;
		issue_valid <= 1'b1;
		issue       <= op;
		@(negedge clk);
		seed_value = rf_value;
		if (no_stall && issue_stall) begin
			errors++;
			$display("tag %02h stalled inside a back-to-back run", op.tag);
		end
		while (issue_stall && (waited < TIMEOUT)) begin
			waited++;
			@(negedge clk);
		end
		accepted = !issue_stall;
		if (!accepted) begin
			errors++;
			$display("timeout while tag %02h waited to be issued", op.tag);
		end
		@(posedge clk);
	endtask

	always @(negedge clk) begin
		if (!arst_n) begin
			if (retire.valid === 1'b1) begin
				errors++;
				$display("retire_o was valid during reset at %0t", $time);
			end
		end else if (retire.valid) begin
			checks++;
			if (exp_seq[retire.tag] == -1) begin
				errors++;
				$display("tag %02h retired but was never issued", retire.tag);
			end else if (retired[retire.tag]) begin
				errors++;
				$display("tag %02h retired a second time", retire.tag);
			end else begin
				retired[retire.tag] = 1'b1;
				retired_count++;
				if (retire.rd != exp_rd[retire.tag]) begin
					errors++;
					$display("mismatch at %0t: retire_o.rd for tag %02h, expected %0d, got %0d",
						$time, retire.tag, exp_rd[retire.tag], retire.rd);
				end
				if (retire.data != exp_data[retire.tag]) begin
					errors++;
					$display("mismatch at %0t: retire_o.data for tag %02h, expected %08h, got %08h",
						$time, retire.tag, exp_data[retire.tag], retire.data);
				end
				if (exp_seq[retire.tag] < last_seq[retire.rd]) begin
					errors++;
					$display("tag %02h retired ahead of an older write to r%0d",
						retire.tag, retire.rd);
				end
				last_seq[retire.rd] = exp_seq[retire.tag];
			end
		end
	end

	initial begin
		logic [XLEN-1:0] value;
		step_t           s;
		int              gap;
		int              waited;
		logic            accepted;
		logic            timed_out;
		void'($urandom(63478));
		arst_n      = 1'b0;
		issue_valid = 1'b0;
		issue       = '0;
		seed_value  = '0;
		issued        = 0;
		retired_count = 0;
		checks        = 0;
		errors        = 0;
		timed_out     = 1'b0;
		foreach (exp_seq[t]) begin
			exp_seq[t] = -1;
			retired[t] = 1'b0;
		end
		foreach (last_seq[r]) begin
			last_seq[r] = -1;
			ref_regs[r] = '0;
		end
		load_table();
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);

		// Preload by ADD rk, rk, r0 while the register file read port A is overridden
		force DUT.rf_data_a = seed_value;
		for (int k = 1; (k < NUM_REGS) && !timed_out; k++) begin
			value = (fixed_seed[k] != '0) ? fixed_seed[k] : $urandom();
			s = row(ADD, k, k, 0, k, 1'b1);
			ref_regs[k] = value;
			expect_result(s.op, value);
			issue_op(s.op, s.chain, value, accepted);
			timed_out = !accepted;
		end
		issue_valid <= 1'b0;
		@(negedge clk);
		release DUT.rf_data_a;
		@(posedge clk);

		for (int i = 0; (i < steps.size()) && !timed_out; i++) begin
			s = steps[i];
			gap = s.chain ? 0 : $urandom_range(3, 0);
			if (gap > 0) begin
				issue_valid <= 1'b0;
				repeat (gap) @(posedge clk);
			end
			value = reference_result(s.op.op, ref_regs[s.op.rs1], ref_regs[s.op.rs2]);
			expect_result(s.op, value);
			if (s.op.rd != '0)
				ref_regs[s.op.rd] = value;
			issue_op(s.op, s.chain, '0, accepted);
			timed_out = !accepted;
		end
		issue_valid <= 1'b0;

		if (!timed_out) begin
			waited = 0;
			while ((retired_count < issued) && (waited < TIMEOUT)) begin
				waited++;
				@(negedge clk);
			end
			if (retired_count < issued) begin
				errors++;
				$display("timeout with %0d of %0d operations retired", retired_count, issued);
				foreach (exp_seq[t]) begin
					if (exp_seq[t] != -1 && !retired[t])
						$display("tag %02h never retired", t);
				end
			end else begin
				// Room for a late duplicate retirement
				repeat (MULT_STAGES + 4) @(negedge clk);
			end
		end
		finish_run();
	end

endmodule

/* list.f */
+incdir+dv
design/vi_pkg.sv
design/int_registers.sv
design/int_alu.sv
design/mult_pipe.sv
design/issue_stage.sv
design/exe_write_latch.sv
design/vi_exec_core.sv
dv/tb_vi_exec_core.sv

/* Bender.yml */
package:
  name: vi_exec_core

sources:
  - design/vi_pkg.sv
  - design/int_registers.sv
  - design/int_alu.sv
  - design/mult_pipe.sv
  - design/issue_stage.sv
  - design/exe_write_latch.sv
  - design/vi_exec_core.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_vi_exec_core.sv
